// File: mdll_cfg.svh
`ifndef MDLL_CFG_SVH
`define MDLL_CFG_SVH

// --------------------------------------------------------------------------
// feedback divider
// --------------------------------------------------------------------------

// largest ratio exponent, clk_fb = osc_0 / 2**ndiv
`define MDLL_N_DIV    6
// counter covers the full 2**MDLL_N_DIV period
`define MDLL_CNT_W    `MDLL_N_DIV

// --------------------------------------------------------------------------
// sigma-delta modulator
// --------------------------------------------------------------------------

`define MDLL_FRAC_W   8     // fractional word, 1/256 resolution

// --------------------------------------------------------------------------
// loop filter / dco code
// --------------------------------------------------------------------------

`define MDLL_DCO_W    10    // dco control code width
`define MDLL_DCO_MID  512   // integrator start, mid range
`define MDLL_DCO_MAX  1023  // upper saturation of the code
// gain shift width, step = 2**gain
`define MDLL_GAIN_W   3

`endif

// File: mdll_pkg.sv
`include "mdll_cfg.svh"

package mdll_pkg;

  // --------------------------------------------------------------------------
  // divider side
  // --------------------------------------------------------------------------

  // ratio exponent, 1..MDLL_N_DIV
  typedef logic [$clog2(`MDLL_N_DIV+1)-1:0] ndiv_t;

  // sdm clock select, 0 -> osc_0/2, k -> osc_0/2**(k+1)
  typedef logic [$clog2(`MDLL_N_DIV+1)-1:0] sel_t;

  typedef logic [`MDLL_CNT_W-1:0] cnt_t;  // divider count

  // --------------------------------------------------------------------------
  // control path
  // --------------------------------------------------------------------------

  typedef logic [`MDLL_FRAC_W-1:0] frac_t;      // fractional word / sdm accumulator
  typedef logic [`MDLL_DCO_W-1:0]  dco_code_t;  // integrator and output code

  // loop gain as a shift amount
  typedef logic [`MDLL_GAIN_W-1:0] gain_t;

endpackage

// File: mdll_feedback_div.sv
`include "mdll_cfg.svh"

module mdll_feedback_div (
  input  logic            osc_0,
  input  logic            rst,
  input  mdll_pkg::ndiv_t ndiv,         // ratio exponent, taken at the wrap
  input  mdll_pkg::sel_t  sel_sdm_clk,  // sdm clock select
  output logic            clk_fb,       // feedback clock, equal halves
  output logic            clk_sdm,      // clock for the modulator
  output logic            last_cycle,   // osc_0 cycle before clk_fb rises
  output logic            fb_tick,      // first high cycle of clk_fb
  output logic            sdm_tick      // first high cycle of clk_sdm
);
  import mdll_pkg::*;

  // --------------------------------------------------------------------------
  // state and next values
  // --------------------------------------------------------------------------

  logic  osc_0_div2;      // plain toggle, osc_0/2
  ndiv_t ratio;           // active exponent for this period
  ndiv_t ratio_nxt;       // clamped ndiv
  cnt_t  cnt;
  cnt_t  cnt_top;         // 2**ratio - 1
  cnt_t  half_m1;         // 2**(ratio-1) - 1
  cnt_t  sdm_src;         // candidate sdm clocks by select
  logic  wrap;
  logic  clk_fb_nxt;
  logic  last_cycle_nxt;
  logic  clk_sdm_nxt;

  // keep the exponent inside 1..MDLL_N_DIV
  always_comb begin
    if (ndiv == '0) begin
      ratio_nxt = ndiv_t'(1);
    end else if (ndiv > ndiv_t'(`MDLL_N_DIV)) begin
      ratio_nxt = ndiv_t'(`MDLL_N_DIV);
    end else begin
      ratio_nxt = ndiv;
    end
  end

  assign cnt_top = cnt_t'({`MDLL_CNT_W{1'b1}} >> (`MDLL_CNT_W - ratio));
  assign half_m1 = cnt_top >> 1;
  assign wrap    = (cnt == cnt_top);

  assign clk_fb_nxt     = (cnt > half_m1);   // upper half of the count
  assign last_cycle_nxt = (cnt == half_m1);  // clk_fb rises one cycle later

  // bit 0 slot is the toggle, bit k of cnt divides by 2**(k+1)
  assign sdm_src     = {cnt[`MDLL_CNT_W-1:1], osc_0_div2};
  assign clk_sdm_nxt = (sel_sdm_clk < sel_t'(`MDLL_CNT_W)) ? sdm_src[sel_sdm_clk] : 1'b0;

  // --------------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------------

  always_ff @(posedge osc_0) begin
    if (rst) begin
      osc_0_div2 <= 1'b0;
      ratio      <= ratio_nxt;  // first period uses the ndiv seen in reset
      cnt        <= '0;
      clk_fb     <= 1'b0;
      last_cycle <= 1'b0;
      fb_tick    <= 1'b0;
      clk_sdm    <= 1'b0;
      sdm_tick   <= 1'b0;
    end else begin
      osc_0_div2 <= ~osc_0_div2;
      if (wrap) begin
        cnt   <= '0;
        ratio <= ratio_nxt;     // new ratio only from the next period
      end else begin
        cnt <= cnt + cnt_t'(1);
      end
      clk_fb     <= clk_fb_nxt;
      last_cycle <= last_cycle_nxt;
      fb_tick    <= clk_fb_nxt & ~clk_fb;    // rising edge
      clk_sdm    <= clk_sdm_nxt;
      sdm_tick   <= clk_sdm_nxt & ~clk_sdm;  // rising edge
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // tick comes from the edge detect, flag from the count compare
  a_tick_after_last: assert property (
    @(posedge osc_0) disable iff (rst) fb_tick |-> $past(last_cycle)
  );

  a_last_single: assert property (
    @(posedge osc_0) disable iff (rst)
      (last_cycle && ratio > ndiv_t'(1)) |=> !last_cycle
  );

endmodule

// File: mdll_sdm.sv
`include "mdll_cfg.svh"

module mdll_sdm (
  input  logic            osc_0,
  input  logic            rst,
  input  logic            sdm_tick,  // one pulse per sdm clock period
  input  mdll_pkg::frac_t frac,      // fractional control word
  output logic            dither     // carry out, density frac/256
);
  import mdll_pkg::*;

  // --------------------------------------------------------------------------
  // first-order accumulator
  // --------------------------------------------------------------------------

  frac_t                acc;  // residue, the error fed back
  logic [`MDLL_FRAC_W:0] sum;  // with carry

  assign sum = {1'b0, acc} + {1'b0, frac};

  // acc and dither move together, only on a tick
  always_ff @(posedge osc_0) begin
    if (rst) begin
      acc    <= '0;
      dither <= 1'b0;
    end else if (sdm_tick) begin
      acc    <= sum[`MDLL_FRAC_W-1:0];  // wraps mod 256
      dither <= sum[`MDLL_FRAC_W];      // overflow is the output bit
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // dither holds between ticks
  a_dither_on_tick: assert property (
    @(posedge osc_0) disable iff (rst) $changed(dither) |-> $past(sdm_tick)
  );

endmodule

// File: mdll_loop_filter.sv
`include "mdll_cfg.svh"

module mdll_loop_filter (
  input  logic                osc_0,
  input  logic                rst,
  input  logic                fb_tick,   // once per feedback period
  input  logic                pd_lead,   // sampled phase result (1 = dco too fast)
  input  mdll_pkg::gain_t     gain,      // step = 2**gain
  input  logic                dither,    // from the modulator
  output mdll_pkg::dco_code_t dco_code
);
  import mdll_pkg::*;

  // --------------------------------------------------------------------------
  // integral path
  // --------------------------------------------------------------------------

  localparam logic [`MDLL_DCO_W:0] code_max_ext = `MDLL_DCO_MAX;  // one bit wider

  dco_code_t             integ;      // integrator
  dco_code_t             integ_nxt;
  dco_code_t             step;
  dco_code_t             code_nxt;
  logic [`MDLL_DCO_W:0]  up_sum;     // room for overflow
  logic [`MDLL_DCO_W:0]  out_sum;

  assign step   = dco_code_t'(1) << gain;
  assign up_sum = {1'b0, integ} + {1'b0, step};

  always_comb begin
    if (pd_lead) begin
      // dco leads so slow it down
      if (integ < step) begin
        integ_nxt = '0;             // floor
      end else begin
        integ_nxt = integ - step;
      end
    end else begin
      if (up_sum > code_max_ext) begin
        integ_nxt = dco_code_t'(`MDLL_DCO_MAX);  // ceiling
      end else begin
        integ_nxt = up_sum[`MDLL_DCO_W-1:0];
      end
    end
  end

  // --------------------------------------------------------------------------
  // output sum with dither
  // --------------------------------------------------------------------------

  assign out_sum  = {1'b0, integ} + {{`MDLL_DCO_W{1'b0}}, dither};
  assign code_nxt = (out_sum > code_max_ext) ? dco_code_t'(`MDLL_DCO_MAX)
                                             : out_sum[`MDLL_DCO_W-1:0];

  always_ff @(posedge osc_0) begin
    if (rst) begin
      integ    <= dco_code_t'(`MDLL_DCO_MID);
      dco_code <= dco_code_t'(`MDLL_DCO_MID);
    end else begin
      if (fb_tick) begin
        integ <= integ_nxt;  // one step per period
      end
      dco_code <= code_nxt;  // second stage 2 cycles after the tick
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // dither on top of a full integrator saturates instead of wrapping to 0
  a_code_no_wrap: assert property (
    @(posedge osc_0) disable iff (rst) dco_code >= $past(integ)
  );

endmodule

// File: mdll_digital_top.sv
module mdll_digital_top (
  input  logic                osc_0,
  input  logic                rst,
  input  mdll_pkg::ndiv_t     ndiv,         // feedback ratio exponent
  input  mdll_pkg::sel_t      sel_sdm_clk,
  input  mdll_pkg::frac_t     frac,         // fractional code word
  input  logic                pd_lead,      // from the phase detector sampler
  input  mdll_pkg::gain_t     gain,
  output logic                clk_fb,
  output logic                clk_sdm,
  output logic                last_cycle,   // to the reference injection
  output mdll_pkg::dco_code_t dco_code
);

  // --------------------------------------------------------------------------
  // internal pulses and dither
  // --------------------------------------------------------------------------

  logic fb_tick;   // divider -> loop filter
  logic sdm_tick;  // divider -> modulator
  logic dither;    // modulator -> loop filter

  mdll_feedback_div mdll_feedback_div_inst (
    .osc_0       (osc_0),
    .rst         (rst),
    .ndiv        (ndiv),
    .sel_sdm_clk (sel_sdm_clk),
    .clk_fb      (clk_fb),
    .clk_sdm     (clk_sdm),
    .last_cycle  (last_cycle),
    .fb_tick     (fb_tick),
    .sdm_tick    (sdm_tick)
  );

  mdll_sdm mdll_sdm_inst (
    .osc_0    (osc_0),
    .rst      (rst),
    .sdm_tick (sdm_tick),
    .frac     (frac),
    .dither   (dither)
  );

  // integrator steps once per clk_fb period
  mdll_loop_filter mdll_loop_filter_inst (
    .osc_0    (osc_0),
    .rst      (rst),
    .fb_tick  (fb_tick),
    .pd_lead  (pd_lead),
    .gain     (gain),
    .dither   (dither),
    .dco_code (dco_code)
  );

endmodule

// File: tb_mdll_digital.sv
`include "mdll_cfg.svh"

module tb_mdll_digital;
  import mdll_pkg::*;

  localparam int SEG_NUM     = 20;   // random segments
  localparam int SEG_LEN     = 300;  // cycles per segment
  localparam int DENS_NUM    = 3;    // dither density windows
  localparam int DENS_SETTLE = 160;  // let frac and ratio settle first
  localparam int DENS_LEN    = DENS_SETTLE + 2 * 256;  // 256 ticks at osc_0/2
  localparam int CYCLE_LIMIT = 2 + SEG_NUM * SEG_LEN + DENS_NUM * DENS_LEN + 200;

  logic      osc_0 = 1'b0;
  logic      rst;
  ndiv_t     ndiv;
  sel_t      sel_sdm_clk;
  frac_t     frac;
  logic      pd_lead;
  gain_t     gain;
  logic      clk_fb;
  logic      clk_sdm;
  logic      last_cycle;
  dco_code_t dco_code;

  // reference model state, updated on the rising edge
  logic      m_div2, m_clk_fb, m_last, m_fb_tick, m_clk_sdm, m_sdm_tick, m_dither;
  ndiv_t     m_ratio;
  cnt_t      m_cnt;
  frac_t     m_acc;
  dco_code_t m_integ, m_code;
  dco_code_t m_base;        // integrator value behind the current code
  logic      m_in_rst;
  logic      model_valid = 1'b0;

  int cycles = 0;
  int fb_periods = 0;
  int bit_errs = 0, code_errs = 0, count_errs = 0;
  logic counting = 1'b0;    // density window open
  logic dens_mode = 1'b0;
  int dens_ticks, dens_ones;

  mdll_digital_top mdll_digital_top_inst (
    .osc_0       (osc_0),
    .rst         (rst),
    .ndiv        (ndiv),
    .sel_sdm_clk (sel_sdm_clk),
    .frac        (frac),
    .pd_lead     (pd_lead),
    .gain        (gain),
    .clk_fb      (clk_fb),
    .clk_sdm     (clk_sdm),
    .last_cycle  (last_cycle),
    .dco_code    (dco_code)
  );

  always #2 osc_0 = ~osc_0;  // period 4

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("error %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_code(input string name, input dco_code_t exp, input dco_code_t act);
    if (act !== exp) begin
      code_errs++;
      $display("error %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errs++;
      $display("error %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // model step, watchdog and pd_lead stimulus
  // --------------------------------------------------------------------------

  always @(posedge osc_0) begin : model_step
    int   half, top, acc_sum, step_val;
    logic n_fb, n_last, n_src;
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("errors: bit %0d, code %0d, count %0d", bit_errs, code_errs, count_errs);
      $display("Checks failed");
      $finish;
    end else begin
      m_in_rst    = rst;
      model_valid = 1'b1;
      if (rst) begin
        m_div2 = 1'b0;
        m_ratio = ndiv;      // first period takes ndiv seen in reset
        m_cnt = '0;
        m_clk_fb = 1'b0;
        m_last = 1'b0;
        m_fb_tick = 1'b0;
        m_clk_sdm = 1'b0;
        m_sdm_tick = 1'b0;
        m_acc = '0;
        m_dither = 1'b0;
        m_integ = dco_code_t'(`MDLL_DCO_MID);
        m_code = dco_code_t'(`MDLL_DCO_MID);
        m_base = dco_code_t'(`MDLL_DCO_MID);
      end else begin
        half   = 1 << (m_ratio - 1);       // cycles per half period
        top    = (1 << m_ratio) - 1;
        n_fb   = (int'(m_cnt) >= half);    // clk_fb high in the upper half
        n_last = (int'(m_cnt) == half - 1);
        n_src  = (sel_sdm_clk == '0) ? m_div2 : m_cnt[sel_sdm_clk];
        // output register sees last cycle's integrator and dither
        m_base = m_integ;
        m_code = (int'(m_integ) + m_dither > `MDLL_DCO_MAX) ?
                 dco_code_t'(`MDLL_DCO_MAX) : m_integ + dco_code_t'(m_dither);
        if (m_fb_tick) begin
          step_val = pd_lead ? -(1 << gain) : (1 << gain);
          step_val = int'(m_integ) + step_val;
          if (step_val < 0) step_val = 0;                          // floor
          if (step_val > `MDLL_DCO_MAX) step_val = `MDLL_DCO_MAX;  // ceiling
          m_integ = dco_code_t'(step_val);
        end
        if (m_sdm_tick) begin
          acc_sum  = int'(m_acc) + int'(frac);
          m_dither = (acc_sum > 255);  // carry
          m_acc    = frac_t'(acc_sum);
        end
        m_fb_tick  = n_fb & ~m_clk_fb;
        m_clk_fb   = n_fb;
        m_last     = n_last;
        m_sdm_tick = n_src & ~m_clk_sdm;
        m_clk_sdm  = n_src;
        if (int'(m_cnt) == top) begin
          m_cnt   = '0;
          m_ratio = ndiv;  // ratio only moves at the wrap
        end else begin
          m_cnt = m_cnt + cnt_t'(1);
        end
        m_div2 = ~m_div2;
      end
      // new phase result per feedback period, bias flips every 40 periods
      if (m_fb_tick) begin
        fb_periods = fb_periods + 1;
        if (dens_mode) begin
          pd_lead <= 1'b1;  // walk down, away from the ceiling
        end else begin
          pd_lead <= ($urandom_range(99, 0) < (((fb_periods / 40) % 2) ? 85 : 15));
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // compare on the falling edge, outputs settled
  // --------------------------------------------------------------------------

  always @(negedge osc_0) begin : compare_step
    string pfx;
    if (model_valid) begin
      pfx = m_in_rst ? "reset" : "run";
      check_bit({pfx, " clk_fb"}, m_clk_fb, clk_fb);
      check_bit({pfx, " last_cycle"}, m_last, last_cycle);
      check_bit({pfx, " clk_sdm"}, m_clk_sdm, clk_sdm);
      check_code({pfx, " dco_code"}, m_code, dco_code);
      if (counting && m_sdm_tick) begin
        dens_ticks = dens_ticks + 1;
        dens_ones  = dens_ones + int'(dco_code) - int'(m_base);  // dither seen in code
      end
    end
  end

  // --------------------------------------------------------------------------
  // sequence: reset, random segments, density windows
  // --------------------------------------------------------------------------

  initial begin : run_tests
    ndiv_t nd;
    frac_t fr;
    void'($urandom(32'he9d4));
    rst = 1'b1;
    ndiv = ndiv_t'(3);
    sel_sdm_clk = '0;
    frac = '0;
    pd_lead = 1'b0;
    gain = '0;
    repeat (2) @(posedge osc_0);
    rst <= 1'b0;
    for (int s = 0; s < SEG_NUM; s++) begin
      nd = ndiv_t'($urandom_range(`MDLL_N_DIV, 1));
      ndiv <= nd;
      sel_sdm_clk <= sel_t'($urandom_range(int'(nd) - 1, 0));
      frac <= frac_t'($urandom);
      gain <= gain_t'($urandom_range(7, 0));
      repeat (SEG_LEN) @(posedge osc_0);
    end
    for (int d = 0; d < DENS_NUM; d++) begin
      fr = frac_t'($urandom);
      ndiv <= ndiv_t'(2);
      sel_sdm_clk <= '0;   // osc_0/2, one tick every 2 cycles
      gain <= '0;
      frac <= fr;
      dens_mode <= 1'b1;
      repeat (DENS_SETTLE) @(posedge osc_0);
      dens_ticks = 0;
      dens_ones  = 0;
      counting   = 1'b1;
      while (dens_ticks < 256) @(posedge osc_0);
      counting = 1'b0;
      check_count("density", int'(fr), dens_ones);
    end
    $display("errors: bit %0d, code %0d, count %0d", bit_errs, code_errs, count_errs);
    if (bit_errs + code_errs + count_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
mdll_pkg.sv
mdll_feedback_div.sv
mdll_sdm.sv
mdll_loop_filter.sv
mdll_digital_top.sv
tb_mdll_digital.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_mdll_digital
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the log
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "simulation ok" || \
		(echo "simulation reported errors"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
